//--- tb.f
rtl/narrator_pkg.sv
rtl/speed_ctrl.sv
rtl/sample_tick_gen.sv
rtl/phoneme_table.sv
rtl/flash_reader.sv
rtl/sample_player.sv
rtl/narrator_top.sv
sim/tb_flash_model.sv
sim/tb_narrator.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the narrator testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_narrator --Mdir obj_dir -f tb.f
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit $status
fi

./obj_dir/Vtb_narrator
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

exit 0

//--- sim/tb_narrator.sv
`timescale 1ns/1ps
`default_nettype none

module tb_narrator;

  localparam int unsigned REPEAT_CYCLES = 16;

  logic                         CLK_50M;
  logic                         arst_n;
  narrator_pkg::speed_keys_t    keys;
  narrator_pkg::phoneme_t       phoneme;
  logic                         start;
  narrator_pkg::flash_rsp_t     flash_rsp;
  narrator_pkg::flash_req_t     flash_req;
  narrator_pkg::sample_t        sample;
  logic                         sample_valid;
  logic                         finish;
  narrator_pkg::divisor_t       divisor;

  narrator_pkg::sample_t        exp_q [$];
  int unsigned                  finish_cnt = 0;
  logic                         reads_forbidden;
  logic                         prev_valid;

  narrator_top #(
    .REPEAT_CYCLES (REPEAT_CYCLES)
  ) i_dut (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .keys         (keys),
    .phoneme      (phoneme),
    .start        (start),
    .flash_rsp    (flash_rsp),
    .flash_req    (flash_req),
    .sample       (sample),
    .sample_valid (sample_valid),
    .finish       (finish),
    .divisor      (divisor)
  );

  tb_flash_model i_flash (
    .CLK_50M   (CLK_50M),
    .arst_n    (arst_n),
    .flash_req (flash_req),
    .flash_rsp (flash_rsp)
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever
      #10 CLK_50M = ~CLK_50M;
  end

  // ==================================================
  // Reference model
  // ==================================================
  function automatic void push_expected(input narrator_pkg::phoneme_t code);
    int unsigned c;
    int unsigned base;
    logic [31:0] data;
    c    = code;
    base = 0;
    if (c == 0 || c >= narrator_pkg::NUM_PHONEMES)
    begin
      for (int unsigned n = 0; n < narrator_pkg::PHONEME_LEN[0] * 4; n++)
        exp_q.push_back('0);
    end
    else
    begin
      for (int unsigned k = 1; k < c; k++)
        base += narrator_pkg::PHONEME_LEN[k];
      for (int unsigned w = 0; w < narrator_pkg::PHONEME_LEN[c]; w++)
      begin
        data = 32'(base + w) * 32'h9e3779b1 + 32'h1234567;
        for (int unsigned b = 0; b < 4; b++)
          exp_q.push_back(data[8*b +: 8]);
      end
    end
  endfunction

  // One key step clamped to the bounds
  function automatic narrator_pkg::divisor_t next_divisor(input narrator_pkg::divisor_t cur,
                                                          input logic faster);
    int d;
    if (faster)
      d = int'(cur) - int'(narrator_pkg::DIVISOR_STEP);
    else
      d = int'(cur) + int'(narrator_pkg::DIVISOR_STEP);
    if (d < int'(narrator_pkg::DIVISOR_MIN))
      d = int'(narrator_pkg::DIVISOR_MIN);
    if (d > int'(narrator_pkg::DIVISOR_MAX))
      d = int'(narrator_pkg::DIVISOR_MAX);
    return narrator_pkg::divisor_t'(d);
  endfunction

  function automatic int unsigned watchdog_cycles();
    int unsigned words;
    words = 3 * narrator_pkg::PHONEME_LEN[0];
    for (int unsigned k = 0; k < narrator_pkg::NUM_PHONEMES; k++)
      words += 2 * narrator_pkg::PHONEME_LEN[k];
    // Samples at the slowest rate, key sweeps and some slack
    return (words * 4 + 16) * narrator_pkg::DIVISOR_MAX + 8 * 256 * REPEAT_CYCLES + 100_000;
  endfunction

  // ==================================================
  // Checks
  // ==================================================
  task automatic abort_run(input string what);
    $display("%s", what);
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_sample(input narrator_pkg::sample_t got, input narrator_pkg::sample_t exp);
    if (got !== exp)
      abort_run($sformatf("error sample got 0x%02h expected 0x%02h", got, exp));
  endtask

  task automatic expect_divisor(input narrator_pkg::divisor_t exp);
    if (divisor !== exp)
      abort_run($sformatf("error divisor got 0x%04h expected 0x%04h", divisor, exp));
  endtask

  task automatic match_finish_count(input int unsigned got, input int unsigned exp);
    if (got != exp)
      abort_run($sformatf("error finish count got 0x%0h expected 0x%0h", got, exp));
  endtask

  // Outputs are sampled on the falling edge
  always @(negedge CLK_50M)
  begin
    if (arst_n)
    begin
      if (sample_valid)
      begin
        if (exp_q.size() == 0)
          abort_run("sample_valid pulsed while no sample was expected");
        else
          check_sample(sample, exp_q.pop_front());
      end
      if (finish)
      begin
        if (exp_q.size() != 0)
          abort_run("finish pulsed before the last expected sample");
        else if (!prev_valid)
          abort_run("finish did not follow the last sample by one cycle");
        else
          finish_cnt++;
      end
      if (flash_req.read && reads_forbidden)
        abort_run("flash read issued while playing a silent phoneme");
    end
    prev_valid = sample_valid;
  end

  initial
  begin
    repeat (watchdog_cycles()) @(posedge CLK_50M);
    abort_run("watchdog expired before the run completed");
  end

  // ==================================================
  // Stimulus
  // ==================================================
  task automatic hold_keys(input narrator_pkg::speed_keys_t k,
                           input narrator_pkg::divisor_t target);
    narrator_pkg::divisor_t prev;
    int unsigned            waited;
    @(negedge CLK_50M);
    keys   = k;
    prev   = divisor;
    waited = 0;
    while (divisor != target)
    begin
      @(negedge CLK_50M);
      if (divisor != prev)
      begin
        expect_divisor(next_divisor(prev, k.up));
        prev = divisor;
      end
      waited++;
      if (waited > 256 * REPEAT_CYCLES)
        abort_run("divisor did not reach its bound while a key was held");
    end
    // Must stay clamped
    repeat (4 * REPEAT_CYCLES) @(negedge CLK_50M);
    expect_divisor(target);
    keys = '0;
  endtask

  task automatic play_phoneme(input narrator_pkg::phoneme_t code, input logic second_start,
                              input narrator_pkg::phoneme_t other);
    int unsigned total;
    int unsigned fin_before;
    push_expected(code);
    total      = exp_q.size();
    fin_before = finish_cnt;
    @(negedge CLK_50M);
    reads_forbidden = (code == 0) || (code >= narrator_pkg::NUM_PHONEMES);
    phoneme         = code;
    start           = 1'b1;
    @(negedge CLK_50M);
    start = 1'b0;
    if (second_start)
    begin
      while (exp_q.size() == total)
        @(negedge CLK_50M);
      phoneme = other;
      start   = 1'b1;
      @(negedge CLK_50M);
      start = 1'b0;
    end
    while (finish_cnt == fin_before)
      @(negedge CLK_50M);
    // Room for a stray second finish or a late sample
    repeat (2 * narrator_pkg::DIVISOR_MIN) @(negedge CLK_50M);
    reads_forbidden = 1'b0;
    match_finish_count(finish_cnt - fin_before, 1);
  endtask

  initial
  begin
    narrator_pkg::phoneme_t order [narrator_pkg::NUM_PHONEMES-1];
    narrator_pkg::phoneme_t tmp;
    narrator_pkg::speed_keys_t k;
    int unsigned            j;
    int unsigned            plays;
    void'($urandom(32'had1411a5));
    arst_n          = 1'b0;
    keys            = '0;
    phoneme         = '0;
    start           = 1'b0;
    reads_forbidden = 1'b0;
    plays           = 0;
    repeat (16) @(negedge CLK_50M);
    arst_n = 1'b1;

    // Idle after reset
    expect_divisor(narrator_pkg::DIVISOR_DEFAULT);
    repeat (4 * REPEAT_CYCLES)
    begin
      @(negedge CLK_50M);
      if (sample_valid || finish || flash_req.read)
        abort_run("an output was active while idle after reset");
    end

    // Both keys at once change nothing
    k = '{up: 1'b1, down: 1'b1, reset: 1'b0};
    @(negedge CLK_50M);
    keys = k;
    repeat (4 * REPEAT_CYCLES) @(negedge CLK_50M);
    expect_divisor(narrator_pkg::DIVISOR_DEFAULT);
    keys = '0;

    hold_keys('{up: 1'b0, down: 1'b1, reset: 1'b0}, narrator_pkg::DIVISOR_MAX);
    @(negedge CLK_50M);
    keys.reset = 1'b1;
    @(negedge CLK_50M);
    keys = '0;
    expect_divisor(narrator_pkg::DIVISOR_DEFAULT);
    // Playback runs at the fastest rate
    hold_keys('{up: 1'b1, down: 1'b0, reset: 1'b0}, narrator_pkg::DIVISOR_MIN);

    for (int unsigned i = 0; i < narrator_pkg::NUM_PHONEMES - 1; i++)
      order[i] = narrator_pkg::phoneme_t'(i + 1);
    for (int unsigned i = narrator_pkg::NUM_PHONEMES - 2; i > 0; i--)
    begin
      j        = $urandom_range(i, 0);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    foreach (order[i])
    begin
      play_phoneme(order[i], 1'b0, '0);
      plays++;
    end

    play_phoneme('0, 1'b0, '0);
    play_phoneme(narrator_pkg::phoneme_t'($urandom_range(255, narrator_pkg::NUM_PHONEMES)),
                 1'b0, '0);
    play_phoneme(order[0], 1'b1, order[1]);
    plays += 3;

    // No stray finish or sample afterwards
    repeat (2 * narrator_pkg::DIVISOR_MIN) @(negedge CLK_50M);
    match_finish_count(finish_cnt, plays);
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/tb_flash_model.sv
`timescale 1ns/1ps
`default_nettype none

module tb_flash_model (
  input  wire logic                     CLK_50M,
  input  wire logic                     arst_n,
  input  wire narrator_pkg::flash_req_t flash_req,
  output narrator_pkg::flash_rsp_t      flash_rsp
);

  logic                      busy;
  int unsigned               latency;
  narrator_pkg::flash_addr_t addr_q;

  // Data word as a fixed function of its address
  function automatic narrator_pkg::flash_word_t word_at(input narrator_pkg::flash_addr_t addr);
    return 32'(addr) * 32'h9e3779b1 + 32'h1234567;
  endfunction

  // Outputs change on the falling edge only
  initial
  begin
    busy      = 1'b0;
    latency   = 0;
    addr_q    = '0;
    flash_rsp = '0;
    forever
    begin
      @(negedge CLK_50M);
      if (!arst_n)
      begin
        busy      = 1'b0;
        flash_rsp = '0;
      end
      else
      begin
        flash_rsp.readdatavalid = 1'b0;
        flash_rsp.readdata      = $urandom;
        flash_rsp.waitrequest   = 1'($urandom_range(0, 1));
        if (busy)
        begin
          if (latency == 0)
          begin
            flash_rsp.readdatavalid = 1'b1;
            flash_rsp.readdata      = word_at(addr_q);
            busy                    = 1'b0;
          end
          else
            latency = latency - 1;
        end
        // Request accepted in this cycle
        else if (flash_req.read && !flash_rsp.waitrequest)
        begin
          busy    = 1'b1;
          addr_q  = flash_req.address;
          latency = $urandom_range(0, 3);
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/narrator_top.sv
`timescale 1ns/1ps
`default_nettype none

module narrator_top #(
  parameter int unsigned REPEAT_CYCLES = 5_000_000
) (
  input  wire logic                      CLK_50M,
  input  wire logic                      arst_n,
  input  wire narrator_pkg::speed_keys_t keys,
  input  wire narrator_pkg::phoneme_t    phoneme,
  input  wire logic                      start,
  input  wire narrator_pkg::flash_rsp_t  flash_rsp,
  output narrator_pkg::flash_req_t       flash_req,
  output narrator_pkg::sample_t          sample,
  output logic                           sample_valid,
  output logic                           finish,
  output narrator_pkg::divisor_t         divisor
);

  logic                         tick;
  logic                         fetch;
  logic                         word_valid;
  narrator_pkg::flash_addr_t    fetch_addr;
  narrator_pkg::flash_word_t    word;
  narrator_pkg::phoneme_range_t range;

  // ==================================================
  // Speed and sample rate
  // ==================================================
  speed_ctrl #(
    .REPEAT_CYCLES (REPEAT_CYCLES)
  ) i_speed_ctrl (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .keys    (keys),
    .divisor (divisor)
  );

  sample_tick_gen i_sample_tick_gen (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .divisor (divisor),
    .tick    (tick)
  );

  // ==================================================
  // Phoneme lookup, player and flash reads
  // ==================================================
  phoneme_table i_phoneme_table (
    .phoneme (phoneme),
    .range   (range)
  );

  sample_player i_sample_player (
    .CLK_50M      (CLK_50M),
    .arst_n       (arst_n),
    .start        (start),
    .range        (range),
    .tick         (tick),
    .word_valid   (word_valid),
    .word         (word),
    .fetch        (fetch),
    .fetch_addr   (fetch_addr),
    .sample       (sample),
    .sample_valid (sample_valid),
    .finish       (finish)
  );

  flash_reader i_flash_reader (
    .CLK_50M    (CLK_50M),
    .arst_n     (arst_n),
    .fetch      (fetch),
    .fetch_addr (fetch_addr),
    .flash_rsp  (flash_rsp),
    .flash_req  (flash_req),
    .word_valid (word_valid),
    .word       (word)
  );

endmodule

`default_nettype wire

//--- rtl/sample_player.sv
`timescale 1ns/1ps
`default_nettype none

module sample_player (
  input  wire logic                         CLK_50M,
  input  wire logic                         arst_n,
  input  wire logic                         start,
  input  wire narrator_pkg::phoneme_range_t range,
  input  wire logic                         tick,
  input  wire logic                         word_valid,
  input  wire narrator_pkg::flash_word_t    word,
  output logic                              fetch,
  output narrator_pkg::flash_addr_t         fetch_addr,
  output narrator_pkg::sample_t             sample,
  output logic                              sample_valid,
  output logic                              finish
);

  localparam int unsigned BYTE_W = $clog2(narrator_pkg::BYTES_PER_WORD);

  typedef enum logic [2:0] {S_IDLE, S_LOAD, S_FETCH, S_PLAY, S_DONE} state_t;

  state_t                    state;
  logic [BYTE_W-1:0]         byte_cnt;
  logic                      pending;
  logic                      last_byte;
  logic                      last_word;
  logic                      silent_q;
  narrator_pkg::flash_addr_t cur_addr;
  narrator_pkg::flash_addr_t end_addr;
  narrator_pkg::flash_word_t word_q;

  assign last_byte  = (byte_cnt == BYTE_W'(narrator_pkg::BYTES_PER_WORD - 1));
  assign last_word  = (cur_addr == end_addr);
  // Silent words never touch the flash
  assign fetch      = (state == S_LOAD) && !silent_q;
  assign fetch_addr = cur_addr;

  // ==================================================
  // Playback FSM
  // ==================================================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state        <= S_IDLE;
      byte_cnt     <= '0;
      sample_valid <= 1'b0;
      finish       <= 1'b0;
    end
    else
    begin
      sample_valid <= 1'b0;
      finish       <= 1'b0;
      case (state)
        S_IDLE:
          if (start)
            state <= S_LOAD;
        S_LOAD:
        begin
          byte_cnt <= '0;
          state    <= silent_q ? S_PLAY : S_FETCH;
        end
        // Ticks in here are dropped
        S_FETCH:
          if (word_valid)
            state <= S_PLAY;
        S_PLAY:
          if (tick)
          begin
            sample_valid <= 1'b1;
            byte_cnt     <= byte_cnt + 1'b1;
            if (last_byte)
              state <= last_word ? S_DONE : S_LOAD;
          end
        S_DONE:
        begin
          finish <= 1'b1;
          state  <= S_IDLE;
        end
        default:
          state <= S_IDLE;
      endcase
    end
  end

  // Range, word and sample registers, low byte out first
  always_ff @(posedge CLK_50M)
  begin
    case (state)
      S_IDLE:
        if (start)
        begin
          cur_addr <= range.start_addr;
          end_addr <= range.end_addr;
          silent_q <= range.silent;
        end
      S_LOAD:
        if (silent_q)
          word_q <= '0;
      S_FETCH:
        if (word_valid)
          word_q <= word;
      S_PLAY:
        if (tick)
        begin
          sample <= word_q[narrator_pkg::SAMPLE_W-1:0];
          word_q <= word_q >> narrator_pkg::SAMPLE_W;
          if (last_byte)
            cur_addr <= cur_addr + 1'b1;
        end
      default:
      begin
      end
    endcase
  end

  // Outstanding read, closed by the reader's word_valid
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      pending <= 1'b0;
    else if (fetch)
      pending <= 1'b1;
    else if (word_valid)
      pending <= 1'b0;
  end

  a_one_fetch: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    fetch |-> !pending);

endmodule

`default_nettype wire

//--- rtl/flash_reader.sv
`timescale 1ns/1ps
`default_nettype none

module flash_reader (
  input  wire logic                       CLK_50M,
  input  wire logic                       arst_n,
  input  wire logic                       fetch,
  input  wire narrator_pkg::flash_addr_t  fetch_addr,
  input  wire narrator_pkg::flash_rsp_t   flash_rsp,
  output narrator_pkg::flash_req_t        flash_req,
  output logic                            word_valid,
  output narrator_pkg::flash_word_t       word
);

  typedef enum logic [1:0] {S_IDLE, S_REQ, S_WAIT} state_t;

  state_t                    state;
  logic                      read_q;
  narrator_pkg::flash_addr_t addr_q;

  assign flash_req.read    = read_q;
  assign flash_req.address = addr_q;

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state      <= S_IDLE;
      read_q     <= 1'b0;
      word_valid <= 1'b0;
    end
    else
    begin
      word_valid <= 1'b0;
      case (state)
        S_IDLE:
          if (fetch)
          begin
            read_q <= 1'b1;
            state  <= S_REQ;
          end
        // Hold read until the flash stops stalling
        S_REQ:
          if (!flash_rsp.waitrequest)
          begin
            read_q <= 1'b0;
            state  <= S_WAIT;
          end
        S_WAIT:
          if (flash_rsp.readdatavalid)
          begin
            word_valid <= 1'b1;
            state      <= S_IDLE;
          end
        default:
          state <= S_IDLE;
      endcase
    end
  end

  // Address and data registers
  always_ff @(posedge CLK_50M)
  begin
    if (state == S_IDLE && fetch)
      addr_q <= fetch_addr;
    if (state == S_WAIT && flash_rsp.readdatavalid)
      word <= flash_rsp.readdata;
  end

  a_addr_stable: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    flash_req.read && flash_rsp.waitrequest |=> flash_req.read && $stable(flash_req.address));

endmodule

`default_nettype wire

//--- rtl/phoneme_table.sv
`timescale 1ns/1ps
`default_nettype none

module phoneme_table (
  input  wire narrator_pkg::phoneme_t phoneme,
  output narrator_pkg::phoneme_range_t range
);

  localparam int unsigned IDX_W = $clog2(narrator_pkg::NUM_PHONEMES);

  // Phoneme n starts after the words of phonemes 1 to n-1
  function automatic int unsigned start_of(input int unsigned code);
    int unsigned sum;
    sum = 0;
    for (int unsigned k = 1; k < code; k++)
      sum += narrator_pkg::PHONEME_LEN[k];
    return sum;
  endfunction

  narrator_pkg::flash_addr_t start_lut [narrator_pkg::NUM_PHONEMES];
  narrator_pkg::flash_addr_t end_lut   [narrator_pkg::NUM_PHONEMES];
  logic                      in_range;
  logic [IDX_W-1:0]          sel;

  for (genvar i = 0; i < narrator_pkg::NUM_PHONEMES; i++)
  begin : g_lut
    localparam int unsigned START = start_of(i);
    localparam int unsigned LEN   = narrator_pkg::PHONEME_LEN[i];

    assign start_lut[i] = narrator_pkg::flash_addr_t'(START);
    assign end_lut[i]   = narrator_pkg::flash_addr_t'(START + LEN - 1);
  end

  // Code 0 and unknown codes fall back to entry 0, the silence length
  assign in_range = (phoneme != '0) && (phoneme < narrator_pkg::NUM_PHONEMES);
  assign sel      = in_range ? phoneme[IDX_W-1:0] : '0;

  always_comb
  begin
    range.start_addr = start_lut[sel];
    range.end_addr   = end_lut[sel];
    range.silent     = !in_range;
  end

endmodule

`default_nettype wire

//--- rtl/sample_tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module sample_tick_gen (
  input  wire logic                   CLK_50M,
  input  wire logic                   arst_n,
  input  wire narrator_pkg::divisor_t divisor,
  output logic                        tick
);

  narrator_pkg::divisor_t cnt;

  // Reload at wrap, so a new divisor lands on the next period
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      cnt  <= narrator_pkg::DIVISOR_DEFAULT - 1'b1;
      tick <= 1'b0;
    end
    else if (cnt == '0)
    begin
      cnt  <= divisor - 1'b1;
      tick <= 1'b1;
    end
    else
    begin
      cnt  <= cnt - 1'b1;
      tick <= 1'b0;
    end
  end

  // Holds only while the speed controller keeps divisor above 1
  a_tick_single: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    tick |=> !tick);

endmodule

`default_nettype wire

//--- rtl/speed_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module speed_ctrl #(
  parameter int unsigned REPEAT_CYCLES = 5_000_000
) (
  input  wire logic                      CLK_50M,
  input  wire logic                      arst_n,
  input  wire narrator_pkg::speed_keys_t keys,
  output narrator_pkg::divisor_t         divisor
);

  localparam int unsigned CNT_W = (REPEAT_CYCLES > 1) ? $clog2(REPEAT_CYCLES) : 1;

  logic [CNT_W-1:0]       rep_cnt;
  logic                   slot;
  narrator_pkg::divisor_t div_faster;
  narrator_pkg::divisor_t div_slower;

  // One decision slot per repeat interval
  assign slot = (rep_cnt == CNT_W'(REPEAT_CYCLES - 1));

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      rep_cnt <= '0;
    else if (slot)
      rep_cnt <= '0;
    else
      rep_cnt <= rep_cnt + 1'b1;
  end

  // Smaller divisor means faster playback
  assign div_faster = (divisor < narrator_pkg::DIVISOR_MIN + narrator_pkg::DIVISOR_STEP) ?
                      narrator_pkg::DIVISOR_MIN : divisor - narrator_pkg::DIVISOR_STEP;
  assign div_slower = (divisor > narrator_pkg::DIVISOR_MAX - narrator_pkg::DIVISOR_STEP) ?
                      narrator_pkg::DIVISOR_MAX : divisor + narrator_pkg::DIVISOR_STEP;

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      divisor <= narrator_pkg::DIVISOR_DEFAULT;
    else if (keys.reset)
      divisor <= narrator_pkg::DIVISOR_DEFAULT;
    else if (slot && keys.up && !keys.down)
      divisor <= div_faster;
    else if (slot && keys.down && !keys.up)
      divisor <= div_slower;
  end

  // Tick generator relies on this range
  a_div_range: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    (divisor >= narrator_pkg::DIVISOR_MIN) && (divisor <= narrator_pkg::DIVISOR_MAX));

endmodule

`default_nettype wire

//--- rtl/narrator_pkg.sv
`default_nettype none

package narrator_pkg;

  // ==================================================
  // Flash bus and sample widths
  // ==================================================
  localparam int unsigned FLASH_ADDR_W   = 23;
  localparam int unsigned FLASH_DATA_W   = 32;
  localparam int unsigned SAMPLE_W       = 8;
  localparam int unsigned BYTES_PER_WORD = 4;
  localparam int unsigned DIVISOR_W      = 16;

  typedef logic [FLASH_ADDR_W-1:0] flash_addr_t;
  typedef logic [FLASH_DATA_W-1:0] flash_word_t;
  typedef logic [SAMPLE_W-1:0]     sample_t;
  typedef logic [DIVISOR_W-1:0]    divisor_t;

  // Driven by the design toward the flash
  typedef struct packed {
    logic        read;
    flash_addr_t address;
  } flash_req_t;

  // Driven by the flash
  typedef struct packed {
    logic        waitrequest;
    logic        readdatavalid;
    flash_word_t readdata;
  } flash_rsp_t;

  // Active-high key levels
  typedef struct packed {
    logic up;
    logic down;
    logic reset;
  } speed_keys_t;

  // ==================================================
  // Phoneme table
  // ==================================================
  typedef logic [7:0] phoneme_t;

  typedef struct packed {
    flash_addr_t start_addr;
    flash_addr_t end_addr;
    logic        silent;
  } phoneme_range_t;

  localparam int unsigned NUM_PHONEMES = 8;

  // Word counts; entry 0 is the silence length in zero words
  localparam int unsigned PHONEME_LEN [NUM_PHONEMES] = '{4, 3, 5, 2, 6, 1, 4, 3};

  // ==================================================
  // Speed divisor, about 7.2 kHz by default
  // ==================================================
  localparam divisor_t DIVISOR_DEFAULT = 16'd6944;
  localparam divisor_t DIVISOR_MIN     = 16'd1000;
  localparam divisor_t DIVISOR_MAX     = 16'd20000;
  localparam divisor_t DIVISOR_STEP    = 16'd100;

endpackage

`default_nettype wire
